/* run_pkg.sv */
package run_pkg;

	// ====================
	// LED strip
	// ====================
	localparam int led_count = 26;

	// bit 0 is the first LED of the strip.
	typedef logic [led_count-1:0] led_frame_t;

	// ====================
	// modes
	// ====================
	typedef logic [2:0] mode_t;

	localparam mode_t mode_stack = 3'd0;
	localparam mode_t mode_bounce = 3'd1;
	localparam mode_t mode_converge = 3'd2;
	localparam mode_t mode_fill = 3'd3;
	localparam mode_t mode_all_on = 3'd4;

	// the auto sequence plays the four running patterns only.
	localparam mode_t auto_last_mode = mode_fill;

	// ====================
	// rates
	// ====================
	typedef logic [2:0] rate_t;

	// selects above rate_last behave like rate_last.
	localparam rate_t rate_last = 3'd4;

	// step period in units of the base period.
	localparam int rate_div [5] = '{1, 2, 4, 8, 16};

	// ====================
	// patterns
	// ====================
	localparam int bounce_len = 5;
	localparam int fill_steps = 17;

	// lit one after the other by the fill pattern, scattered over the strip.
	localparam led_frame_t fill_groups [fill_steps] = '{
		26'h0000001, 26'h0000030, 26'h0400000, 26'h0007000,
		26'h00c0000, 26'h0000300, 26'h3000000, 26'h000000e,
		26'h0028000, 26'h0000080, 26'h0200000, 26'h0000800,
		26'h0800000, 26'h0010000, 26'h0000400, 26'h0000040,
		26'h0100000
	};

endpackage

/* seg_pkg.sv */
package seg_pkg;

	// one digit, bit 6 is segment g and bit 0 is segment a.
	typedef logic [6:0] seg_t;

	// ====================
	// digit encodings
	// ====================

	// the segments are active low, so a lit segment is a 0.
	localparam seg_t seg_digits [10] = '{
		7'b1000000,
		7'b1111001,
		7'b0100100,
		7'b0110000,
		7'b0011001,
		7'b0010010,
		7'b0000010,
		7'b1111000,
		7'b0000000,
		7'b0010000
	};

	localparam seg_t seg_blank = 7'b1111111;

endpackage

/* step_timer.sv */
`timescale 1ns/1ps

module step_timer #(
	parameter int step_unit = 2500000
) (
	input logic hz_led,
	input logic reset,
	input run_pkg::rate_t rate,
	output logic step_tick
);

	localparam int cnt_w = $clog2(step_unit * run_pkg::rate_div[run_pkg::rate_last]);

	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] reload;
	logic armed;
	run_pkg::rate_t rate_idx;

	always_comb begin
		rate_idx = (rate > run_pkg::rate_last) ? run_pkg::rate_last : rate;
		reload = cnt_w'(step_unit * run_pkg::rate_div[rate_idx] - 1);
	end

	// the rate is only sampled when the counter wraps.
	// the zero left by reset loads the first period without a tick.
	always_ff @(posedge hz_led or posedge reset) begin
		if (reset) begin
			count <= '0;
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (count == '0) begin
				count <= reload;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	assign step_tick = armed && (count == '0);

endmodule

/* mode_control.sv */
`timescale 1ns/1ps

module mode_control (
	input logic hz_led,
	input logic reset,
	input logic mode_button,
	input logic auto,
	input logic cycle_done,
	output run_pkg::mode_t mode
);

	logic btn_meta;
	logic btn_sync;
	logic btn_prev;
	logic press;

	// ====================
	// button
	// ====================
	always_ff @(posedge hz_led or posedge reset) begin
		if (reset) begin
			btn_meta <= 1'b0;
			btn_sync <= 1'b0;
			btn_prev <= 1'b0;
		end else begin
			btn_meta <= mode_button;
			btn_sync <= btn_meta;
			btn_prev <= btn_sync;
		end
	end

	assign press = btn_sync && !btn_prev;

	// ====================
	// mode register
	// ====================

	// in auto mode the button is ignored and the end of each pattern
	// moves on to the next one.
	always_ff @(posedge hz_led or posedge reset) begin
		if (reset) begin
			mode <= run_pkg::mode_stack;
		end else if (auto) begin
			if (mode > run_pkg::auto_last_mode) begin
				// all on never ends a cycle, so auto starts over from stack.
				mode <= run_pkg::mode_stack;
			end else if (cycle_done) begin
				if (mode == run_pkg::auto_last_mode) begin
					mode <= run_pkg::mode_stack;
				end else begin
					mode <= mode + 1'b1;
				end
			end
		end else if (press) begin
			if (mode == run_pkg::mode_all_on) begin
				mode <= run_pkg::mode_stack;
			end else begin
				mode <= mode + 1'b1;
			end
		end
	end

endmodule

/* pattern_engine.sv */
`timescale 1ns/1ps

module pattern_engine (
	input logic hz_led,
	input logic reset,
	input logic step_tick,
	input run_pkg::mode_t mode,
	output run_pkg::led_frame_t leds,
	output logic cycle_done
);

	localparam int cnt_w = $clog2(run_pkg::led_count + 1);
	localparam int bounce_top = run_pkg::led_count - run_pkg::bounce_len;
	localparam int half = run_pkg::led_count / 2;
	localparam run_pkg::led_frame_t all_on = '1;
	localparam run_pkg::led_frame_t one_led = run_pkg::led_frame_t'(1);
	localparam run_pkg::led_frame_t bounce_base =
		run_pkg::led_frame_t'((1 << run_pkg::bounce_len) - 1);

	logic [cnt_w-1:0] pos;
	logic [cnt_w-1:0] fill;
	logic dir;
	run_pkg::mode_t mode_prev;

	logic [cnt_w-1:0] pos_next;
	logic [cnt_w-1:0] fill_next;
	logic dir_next;
	logic last;
	run_pkg::led_frame_t frame_next;
	run_pkg::led_frame_t top_mask;

	// ====================
	// next frame
	// ====================

	// last marks the step that blanks the strip and starts the pattern over.
	always_comb begin
		pos_next = pos;
		fill_next = fill;
		dir_next = dir;
		frame_next = leds;
		last = 1'b0;
		top_mask = ~(all_on >> fill);
		case (mode)
			run_pkg::mode_stack: begin
				if (&leds) begin
					last = 1'b1;
				end else begin
					// fill counts the LEDs already stacked at the top.
					frame_next = top_mask | (one_led << pos);
					if (int'(pos) == run_pkg::led_count - 1 - int'(fill)) begin
						fill_next = fill + 1'b1;
						pos_next = '0;
					end else begin
						pos_next = pos + 1'b1;
					end
				end
			end
			run_pkg::mode_bounce: begin
				// on the way down only the block at LED 0 covers bit 0.
				if (dir && leds[0]) begin
					last = 1'b1;
				end else begin
					frame_next = bounce_base << pos;
					if (!dir && int'(pos) == bounce_top) begin
						dir_next = 1'b1;
						pos_next = pos - 1'b1;
					end else if (!dir) begin
						pos_next = pos + 1'b1;
					end else if (pos != '0) begin
						pos_next = pos - 1'b1;
					end
				end
			end
			run_pkg::mode_converge: begin
				if (int'(pos) == half) begin
					last = 1'b1;
				end else begin
					frame_next = (one_led << pos) |
						(one_led << (run_pkg::led_count - 1 - int'(pos)));
					pos_next = pos + 1'b1;
				end
			end
			run_pkg::mode_fill: begin
				// the groups cover the whole strip, so the last one lights it fully.
				if (&leds) begin
					last = 1'b1;
				end else begin
					frame_next = leds | run_pkg::fill_groups[fill];
					fill_next = fill + 1'b1;
				end
			end
			default: begin
				frame_next = all_on;
			end
		endcase
	end

	// ====================
	// frame register
	// ====================
	always_ff @(posedge hz_led or posedge reset) begin
		if (reset) begin
			leds <= '0;
			cycle_done <= 1'b0;
			pos <= '0;
			fill <= '0;
			dir <= 1'b0;
			mode_prev <= run_pkg::mode_stack;
		end else begin
			mode_prev <= mode;
			cycle_done <= 1'b0;
			if (mode != mode_prev) begin
				// a new mode always starts from a dark strip.
				leds <= '0;
				pos <= '0;
				fill <= '0;
				dir <= 1'b0;
			end else if (step_tick) begin
				if (last) begin
					leds <= '0;
					pos <= '0;
					fill <= '0;
					dir <= 1'b0;
					cycle_done <= 1'b1;
				end else begin
					leds <= frame_next;
					pos <= pos_next;
					fill <= fill_next;
					dir <= dir_next;
				end
			end
		end
	end

endmodule

/* seg_display.sv */
`timescale 1ns/1ps

module seg_display (
	input logic hz_led,
	input logic reset,
	input run_pkg::mode_t mode,
	input run_pkg::rate_t rate,
	output seg_pkg::seg_t seg_mode,
	output seg_pkg::seg_t seg_rate
);

	run_pkg::rate_t rate_idx;

	// rates are numbered from 1 on the display.
	assign rate_idx = (rate > run_pkg::rate_last) ? run_pkg::rate_last : rate;

	// ====================
	// digit registers
	// ====================
	always_ff @(posedge hz_led or posedge reset) begin
		if (reset) begin
			seg_mode <= seg_pkg::seg_blank;
			seg_rate <= seg_pkg::seg_blank;
		end else begin
			seg_mode <= seg_pkg::seg_digits[mode];
			seg_rate <= seg_pkg::seg_digits[rate_idx + 1'b1];
		end
	end

endmodule

/* running_led_top.sv */
`timescale 1ns/1ps

module running_led_top #(
	parameter int step_unit = 2500000
) (
	input logic hz_led,
	input logic reset,
	input logic mode_button,
	input logic auto,
	input run_pkg::rate_t rate,
	output run_pkg::led_frame_t leds,
	output seg_pkg::seg_t seg_mode,
	output seg_pkg::seg_t seg_rate
);

	logic step_tick;
	logic cycle_done;
	run_pkg::mode_t mode;

	step_timer #(
		.step_unit(step_unit)
	) u_step_timer (
		.hz_led(hz_led),
		.reset(reset),
		.rate(rate),
		.step_tick(step_tick)
	);

	mode_control u_mode_control (
		.hz_led(hz_led),
		.reset(reset),
		.mode_button(mode_button),
		.auto(auto),
		.cycle_done(cycle_done),
		.mode(mode)
	);

	pattern_engine u_pattern_engine (
		.hz_led(hz_led),
		.reset(reset),
		.step_tick(step_tick),
		.mode(mode),
		.leds(leds),
		.cycle_done(cycle_done)
	);

	seg_display u_seg_display (
		.hz_led(hz_led),
		.reset(reset),
		.mode(mode),
		.rate(rate),
		.seg_mode(seg_mode),
		.seg_rate(seg_rate)
	);

endmodule

/* running_led_tb.sv */
`timescale 1ns/1ps

module running_led_tb;

	localparam int step_unit = 1;
	localparam int row_count = 9;
	localparam int margin = 2000;
	localparam int settle_cycles = 20;

	typedef struct packed {
		int presses;
		int auto_on;
		int rate;
		int frames;
		int mode;
	} row_t;

	// presses, auto, rate, frames to observe, mode at the end of the row.
	localparam row_t rows [row_count] = '{
		'{0, 0, 0, 352, 0},
		'{1, 0, 1, 44, 1},
		'{1, 0, 2, 14, 2},
		'{1, 0, 3, 18, 3},
		'{1, 0, 4, 1, 4},
		'{2, 0, 0, 20, 1},
		'{3, 0, 1, 1, 4},
		'{0, 1, 1, 438, 0},
		'{2, 0, 6, 3, 2}
	};

	logic hz_led = 1'b0;
	logic reset;
	logic mode_button;
	logic auto;
	run_pkg::rate_t rate;
	run_pkg::led_frame_t leds;
	seg_pkg::seg_t seg_mode;
	seg_pkg::seg_t seg_rate;

	int cycles = 0;
	int limit = margin;
	int cur_mode;
	row_t row;
	run_pkg::led_frame_t frame_q [$];
	int owner_q [$];

	running_led_top #(
		.step_unit(step_unit)
	) dut0 (
		.hz_led(hz_led),
		.reset(reset),
		.mode_button(mode_button),
		.auto(auto),
		.rate(rate),
		.leds(leds),
		.seg_mode(seg_mode),
		.seg_rate(seg_rate)
	);

	always #20 hz_led = ~hz_led;

	always @(posedge hz_led) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			abort_run($sformatf("timeout after %0d cycles, the tests did not finish", cycles));
		end
	end

	// ====================
	// checks
	// ====================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	function automatic int rate_index(input int r);
		return (r > 4) ? 4 : r;
	endfunction

	// ====================
	// frame model
	// ====================
	task automatic push_frame(input run_pkg::led_frame_t f, input int m);
		frame_q.push_back(f);
		owner_q.push_back(m);
	endtask

	function automatic run_pkg::led_frame_t block_at(input int p);
		run_pkg::led_frame_t f;
		f = '0;
		for (int i = 0; i < run_pkg::bounce_len; i++) begin
			f[p+i] = 1'b1;
		end
		return f;
	endfunction

	// every pattern but all on ends with a dark frame.
	task automatic append_frames(input int m);
		run_pkg::led_frame_t top;
		run_pkg::led_frame_t f;
		int lvl;
		int p;
		top = '0;
		f = '0;
		case (m)
			0: begin
				for (lvl = 0; lvl < run_pkg::led_count; lvl++) begin
					for (p = 0; p < run_pkg::led_count - lvl; p++) begin
						f = top;
						f[p] = 1'b1;
						push_frame(f, m);
					end
					top[run_pkg::led_count-1-lvl] = 1'b1;
				end
			end
			1: begin
				for (p = 0; p <= run_pkg::led_count - run_pkg::bounce_len; p++) begin
					push_frame(block_at(p), m);
				end
				for (p = run_pkg::led_count - run_pkg::bounce_len - 1; p >= 0; p--) begin
					push_frame(block_at(p), m);
				end
			end
			2: begin
				for (p = 0; p < run_pkg::led_count / 2; p++) begin
					f = '0;
					f[p] = 1'b1;
					f[run_pkg::led_count-1-p] = 1'b1;
					push_frame(f, m);
				end
			end
			3: begin
				for (p = 0; p < run_pkg::fill_steps && !(&f); p++) begin
					f = f | run_pkg::fill_groups[p];
					push_frame(f, m);
				end
			end
			default: begin
				push_frame('1, m);
			end
		endcase
		if (m < 4) begin
			push_frame('0, m);
		end
	endtask

	// ====================
	// stimulus
	// ====================
	task automatic press_button();
		int gap;
		int old_mode;
		gap = 2 + int'($urandom % 4);
		old_mode = cur_mode;
		cur_mode = (cur_mode == 4) ? 0 : cur_mode + 1;
		repeat (gap) @(posedge hz_led);
		mode_button <= 1'b1;
		repeat (3) @(posedge hz_led);
		@(negedge hz_led);
		compare("seg_mode", 32'(seg_mode), 32'(seg_pkg::seg_digits[old_mode]));
		@(posedge hz_led);
		mode_button <= 1'b0;
		@(negedge hz_led);
		compare("seg_mode", 32'(seg_mode), 32'(seg_pkg::seg_digits[cur_mode]));
		compare("leds", 32'(leds), 32'(0));
	endtask

	// starts at a falling edge with the pattern at its dark start frame.
	task automatic observe_frames(input int count, input int auto_on, input int period);
		run_pkg::led_frame_t prev;
		int seen;
		int gap;
		int idx;
		prev = leds;
		seen = 0;
		gap = 0;
		while (seen < count) begin
			@(negedge hz_led);
			gap++;
			if (leds !== prev) begin
				idx = seen % frame_q.size();
				compare("leds", 32'(leds), 32'(frame_q[idx]));
				compare("seg_mode", 32'(seg_mode), 32'(seg_pkg::seg_digits[owner_q[idx]]));
				if (auto_on == 0 && seen > 0) begin
					compare("step period", gap, period);
				end
				prev = leds;
				gap = 0;
				seen++;
			end
		end
	endtask

	initial begin
		void'($urandom(95944));
		reset = 1'b1;
		mode_button = 1'b0;
		auto = 1'b0;
		rate = '0;
		cur_mode = 0;
		for (int r = 0; r < row_count; r++) begin
			limit += rows[r].frames * 16 * step_unit;
		end

		repeat (10) @(posedge hz_led);
		reset <= 1'b0;
		@(posedge hz_led);
		@(negedge hz_led);
		compare("leds", 32'(leds), 32'(0));
		compare("seg_mode", 32'(seg_mode), 32'(seg_pkg::seg_digits[0]));
		compare("seg_rate", 32'(seg_rate), 32'(seg_pkg::seg_digits[rate_index(0) + 1]));

		for (int r = 0; r < row_count; r++) begin
			row = rows[r];
			if (row.rate != int'(rate)) begin
				@(posedge hz_led);
				rate <= run_pkg::rate_t'(row.rate);
				repeat (settle_cycles) @(posedge hz_led);
				@(negedge hz_led);
			end
			if ((row.auto_on != 0) != auto) begin
				@(posedge hz_led);
				auto <= (row.auto_on != 0);
				repeat (2) @(posedge hz_led);
				@(negedge hz_led);
			end
			for (int k = 0; k < row.presses; k++) begin
				press_button();
			end
			compare("seg_rate", 32'(seg_rate),
				32'(seg_pkg::seg_digits[rate_index(row.rate) + 1]));

			frame_q.delete();
			owner_q.delete();
			if (row.auto_on != 0) begin
				for (int m = 0; m <= 3; m++) begin
					append_frames(m);
				end
			end else begin
				append_frames(cur_mode);
			end
			observe_frames(row.frames, row.auto_on,
				run_pkg::rate_div[rate_index(row.rate)] * step_unit);
			cur_mode = owner_q[(row.frames - 1) % owner_q.size()];
			compare("seg_mode", 32'(seg_mode), 32'(seg_pkg::seg_digits[row.mode]));
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* list.f */
run_pkg.sv
seg_pkg.sv
step_timer.sv
mode_control.sv
pattern_engine.sv
seg_display.sv
running_led_top.sv
running_led_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module running_led_tb -f list.f -o running_led_sim \
	&& ./obj_dir/running_led_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Simulation finished: PASS" sim.log \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
